// File: hdl/deparser_pkg.sv
package deparser_pkg;

	// stream widths
	localparam int DATA_W = 256;
	localparam int KEEP_W = DATA_W / 8;
	localparam int USER_W = 128;

	// phv layout
	localparam int PHV_W = 1124;
	localparam int PHV_DISCARD_BIT = 128;
	localparam int PHV_VLAN_POS = 129;
	localparam int PHV_2B_POS = 356;
	localparam int PHV_4B_POS = 484;
	localparam int PHV_6B_POS = 740;
	localparam int CONT_W = 48;

	// action table
	localparam int NUM_ACT = 10;
	localparam int ACT_W = 16;
	localparam int ENTRY_W = NUM_ACT * ACT_W;
	localparam int TBL_DEPTH = 16;
	localparam int TBL_AW = $clog2(TBL_DEPTH);
	// vlan id bits 7:4 pick the entry
	localparam int TBL_ADDR_POS = PHV_VLAN_POS + 4;

	localparam int BUF_BEATS = 2;
	localparam int BUF_BYTES = BUF_BEATS * KEEP_W;

	// control stream
	localparam logic [2:0] DEPARSER_MOD_ID = 3'b101;
	localparam int CTRL_MOD_ID_POS = 112;
	localparam int CTRL_ADDR_POS = 128;

	// container type codes
	localparam logic [1:0] CT_NONE = 2'b00;
	localparam logic [1:0] CT_2B = 2'b01;
	localparam logic [1:0] CT_4B = 2'b10;
	localparam logic [1:0] CT_6B = 2'b11;

	typedef struct packed {
		logic [DATA_W-1:0] tdata;
		logic [KEEP_W-1:0] tkeep;
		logic [USER_W-1:0] tuser;
		logic              tlast;
	} axis_beat_t;

	typedef struct packed {
		logic [2:0] rsvd;
		logic [6:0] offset;
		logic [1:0] ctype;
		logic [2:0] idx;
		logic       en;
	} depar_act_t;

	typedef struct packed {
		logic [TBL_AW-1:0]  addr;
		logic [ENTRY_W-1:0] data;
		logic               en;
	} tbl_wr_t;

	// container right-aligned, destination byte offset carried along
	typedef struct packed {
		logic [CONT_W-1:0] val;
		logic [6:0]        offset;
		logic [1:0]        ctype;
		logic              valid;
	} field_t;

endpackage

// File: hdl/depar_ctrl_loader.sv
module depar_ctrl_loader (
	input  logic                            clk,
	input  logic                            aresetn,
	input  logic [deparser_pkg::DATA_W-1:0] ctrl_tdata,
	input  logic                            ctrl_tvalid,
	input  logic                            ctrl_tlast,
	output deparser_pkg::tbl_wr_t           tbl_wr
);

	typedef enum logic [1:0] {
		S_HDR,
		S_ID,
		S_DATA,
		S_SKIP
	} state_t;

	state_t state;
	logic mod_hit;
	logic [deparser_pkg::DATA_W-1:0] swapped;
	logic [deparser_pkg::TBL_AW-1:0] wr_addr;
	logic [deparser_pkg::ENTRY_W-1:0] wr_data;
	logic wr_en;

	assign mod_hit = ctrl_tdata[deparser_pkg::CTRL_MOD_ID_POS +: 3] == deparser_pkg::DEPARSER_MOD_ID;

	// control data arrives in network byte order
	always_comb begin
		for (int i = 0; i < deparser_pkg::KEEP_W; i++) begin
			swapped[8*i +: 8] = ctrl_tdata[8*(deparser_pkg::KEEP_W-1-i) +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= S_HDR;
			wr_en <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (ctrl_tvalid) begin
				case (state)
					S_HDR: begin
						if (!ctrl_tlast)
							state <= S_ID;
					end
					S_ID: begin
						if (ctrl_tlast)
							state <= S_HDR;
						else if (mod_hit)
							state <= S_DATA;
						else
							state <= S_SKIP;
					end
					S_DATA: begin
						wr_en <= 1'b1;
						state <= ctrl_tlast ? S_HDR : S_SKIP;
					end
					default: begin
						if (ctrl_tlast)
							state <= S_HDR;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_tvalid && state == S_ID && mod_hit)
			wr_addr <= ctrl_tdata[deparser_pkg::CTRL_ADDR_POS +: deparser_pkg::TBL_AW];
		// entry is the upper part of the swapped beat
		if (ctrl_tvalid && state == S_DATA)
			wr_data <= swapped[deparser_pkg::DATA_W-1 -: deparser_pkg::ENTRY_W];
	end

	assign tbl_wr = '{addr: wr_addr, data: wr_data, en: wr_en};

	a_single_write: assert property (@(posedge clk) disable iff (!aresetn)
		wr_en |=> !wr_en);

endmodule

// File: hdl/depar_action_table.sv
module depar_action_table (
	input  logic                             clk,
	input  deparser_pkg::tbl_wr_t            tbl_wr,
	input  logic [deparser_pkg::TBL_AW-1:0]  rd_addr,
	output logic [deparser_pkg::ENTRY_W-1:0] rd_entry
);

	logic [deparser_pkg::ENTRY_W-1:0] mem [deparser_pkg::TBL_DEPTH];

	always_ff @(posedge clk) begin
		if (tbl_wr.en)
			mem[tbl_wr.addr] <= tbl_wr.data;
	end

	// old contents on a same-address collision
	always_ff @(posedge clk) begin
		rd_entry <= mem[rd_addr];
	end

endmodule

// File: hdl/container_extractor.sv
module container_extractor (
	input  logic                           clk,
	input  logic                           aresetn,
	input  logic                           act_valid,
	input  deparser_pkg::depar_act_t       act,
	input  logic [deparser_pkg::PHV_W-1:0] phv,
	output deparser_pkg::field_t           field
);

	logic [deparser_pkg::CONT_W-1:0] cont;

	always_comb begin
		case (act.ctype)
			deparser_pkg::CT_2B:
				cont = {32'b0, phv[deparser_pkg::PHV_2B_POS + 16*act.idx +: 16]};
			deparser_pkg::CT_4B:
				cont = {16'b0, phv[deparser_pkg::PHV_4B_POS + 32*act.idx +: 32]};
			deparser_pkg::CT_6B:
				cont = phv[deparser_pkg::PHV_6B_POS + 48*act.idx +: 48];
			default:
				cont = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			field.valid <= 1'b0;
		end else if (act_valid) begin
			field.valid <= act.en && act.ctype != deparser_pkg::CT_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (act_valid) begin
			field.val <= cont;
			field.offset <= act.offset;
			field.ctype <= act.ctype;
		end
	end

endmodule

// File: hdl/depar_engine.sv
module depar_engine (
	input  logic                           clk,
	input  logic                           aresetn,
	input  deparser_pkg::axis_beat_t       pkt_in,
	input  logic                           pkt_empty,
	output logic                           pkt_rd_en,
	input  logic [deparser_pkg::PHV_W-1:0] phv_data,
	input  logic                           phv_empty,
	output logic                           phv_rd_en,
	output logic                           act_valid,
	input  deparser_pkg::field_t           fields [deparser_pkg::NUM_ACT],
	output deparser_pkg::axis_beat_t       out_beat,
	output logic                           out_tvalid,
	input  logic                           out_tready
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_CAP1,
		S_ACT,
		S_APPLY,
		S_FLUSH0,
		S_FLUSH1,
		S_PASS,
		S_DROP
	} state_t;

	state_t state;
	state_t state_nxt;
	deparser_pkg::axis_beat_t beat_buf [deparser_pkg::BUF_BEATS];
	logic [deparser_pkg::BUF_BYTES-1:0][7:0] rewr;
	logic start;
	logic discard;

	assign start = !pkt_empty && !phv_empty;
	assign discard = phv_data[deparser_pkg::PHV_DISCARD_BIT];

	always_comb begin
		state_nxt = state;
		pkt_rd_en = 1'b0;
		phv_rd_en = 1'b0;
		act_valid = 1'b0;
		out_tvalid = 1'b0;
		out_beat = beat_buf[0];
		case (state)
			S_IDLE: begin
				if (start) begin
					pkt_rd_en = 1'b1;
					if (discard) begin
						phv_rd_en = 1'b1;
						state_nxt = pkt_in.tlast ? S_IDLE : S_DROP;
					end else begin
						state_nxt = pkt_in.tlast ? S_ACT : S_CAP1;
					end
				end
			end
			S_CAP1: begin
				if (!pkt_empty) begin
					pkt_rd_en = 1'b1;
					state_nxt = S_ACT;
				end
			end
			S_ACT: begin
				act_valid = 1'b1;
				state_nxt = S_APPLY;
			end
			S_APPLY: begin
				state_nxt = S_FLUSH0;
			end
			S_FLUSH0: begin
				out_tvalid = 1'b1;
				// phv leaves with the first beat
				if (out_tready) begin
					phv_rd_en = 1'b1;
					state_nxt = beat_buf[0].tlast ? S_IDLE : S_FLUSH1;
				end
			end
			S_FLUSH1: begin
				out_beat = beat_buf[1];
				out_tvalid = 1'b1;
				if (out_tready)
					state_nxt = beat_buf[1].tlast ? S_IDLE : S_PASS;
			end
			S_PASS: begin
				out_beat = pkt_in;
				out_tvalid = !pkt_empty;
				pkt_rd_en = !pkt_empty && out_tready;
				if (pkt_rd_en && pkt_in.tlast)
					state_nxt = S_IDLE;
			end
			S_DROP: begin
				pkt_rd_en = !pkt_empty;
				if (pkt_rd_en && pkt_in.tlast)
					state_nxt = S_IDLE;
			end
			default: begin
				state_nxt = S_IDLE;
			end
		endcase
	end

	// msb of the container lands on the lowest byte, later actions win
	always_comb begin : apply_fields
		int n;
		int o;
		rewr = {beat_buf[1].tdata, beat_buf[0].tdata};
		for (int a = 0; a < deparser_pkg::NUM_ACT; a++) begin
			case (fields[a].ctype)
				deparser_pkg::CT_2B: n = 2;
				deparser_pkg::CT_4B: n = 4;
				deparser_pkg::CT_6B: n = 6;
				default: n = 0;
			endcase
			o = int'(fields[a].offset);
			if (fields[a].valid && o + n <= deparser_pkg::BUF_BYTES) begin
				for (int k = 0; k < deparser_pkg::CONT_W / 8; k++) begin
					if (k < n)
						rewr[o + k] = fields[a].val[8*(n-1-k) +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			state <= S_IDLE;
		else
			state <= state_nxt;
	end

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				// first beat carries the phv metadata as tuser
				if (start) begin
					beat_buf[0] <= '{
						tdata: pkt_in.tdata,
						tkeep: pkt_in.tkeep,
						tuser: phv_data[deparser_pkg::USER_W-1:0],
						tlast: pkt_in.tlast
					};
				end
			end
			S_CAP1: begin
				if (!pkt_empty)
					beat_buf[1] <= pkt_in;
			end
			S_APPLY: begin
				beat_buf[0].tdata <= rewr[deparser_pkg::KEEP_W-1:0];
				beat_buf[1].tdata <= rewr[deparser_pkg::BUF_BYTES-1:deparser_pkg::KEEP_W];
			end
			default: begin
			end
		endcase
	end

	a_out_hold: assert property (@(posedge clk) disable iff (!aresetn)
		out_tvalid && !out_tready |=> out_tvalid && $stable(out_beat));

	a_no_empty_read: assert property (@(posedge clk) disable iff (!aresetn)
		!(pkt_rd_en && pkt_empty) && !(phv_rd_en && phv_empty));

endmodule

// File: hdl/deparser_top.sv
module deparser_top (
	input  logic                              clk,
	input  logic                              aresetn,

	input  logic [deparser_pkg::DATA_W-1:0]   pkt_tdata,
	input  logic [deparser_pkg::KEEP_W-1:0]   pkt_tkeep,
	input  logic [deparser_pkg::USER_W-1:0]   pkt_tuser,
	input  logic                              pkt_tlast,
	input  logic                              pkt_empty,
	output logic                              pkt_rd_en,

	input  logic [deparser_pkg::PHV_W-1:0]    phv_data,
	input  logic                              phv_empty,
	output logic                              phv_rd_en,

	output logic [deparser_pkg::DATA_W-1:0]   out_tdata,
	output logic [deparser_pkg::KEEP_W-1:0]   out_tkeep,
	output logic [deparser_pkg::USER_W-1:0]   out_tuser,
	output logic                              out_tlast,
	output logic                              out_tvalid,
	input  logic                              out_tready,

	input  logic [deparser_pkg::DATA_W-1:0]   ctrl_tdata,
	input  logic                              ctrl_tvalid,
	input  logic                              ctrl_tlast
);

	deparser_pkg::axis_beat_t pkt_in;
	deparser_pkg::axis_beat_t out_beat;
	deparser_pkg::tbl_wr_t tbl_wr;
	logic [deparser_pkg::ENTRY_W-1:0] rd_entry;
	logic act_valid;
	deparser_pkg::field_t fields [deparser_pkg::NUM_ACT];

	assign pkt_in = '{tdata: pkt_tdata, tkeep: pkt_tkeep, tuser: pkt_tuser, tlast: pkt_tlast};

	assign out_tdata = out_beat.tdata;
	assign out_tkeep = out_beat.tkeep;
	assign out_tuser = out_beat.tuser;
	assign out_tlast = out_beat.tlast;

	depar_ctrl_loader u_loader (
		.clk         (clk),
		.aresetn     (aresetn),
		.ctrl_tdata  (ctrl_tdata),
		.ctrl_tvalid (ctrl_tvalid),
		.ctrl_tlast  (ctrl_tlast),
		.tbl_wr      (tbl_wr)
	);

	depar_action_table u_table (
		.clk      (clk),
		.tbl_wr   (tbl_wr),
		.rd_addr  (phv_data[deparser_pkg::TBL_ADDR_POS +: deparser_pkg::TBL_AW]),
		.rd_entry (rd_entry)
	);

	// action 0 sits in the top 16 bits of the entry
	for (genvar i = 0; i < deparser_pkg::NUM_ACT; i++) begin : g_ext
		deparser_pkg::depar_act_t act;

		assign act = rd_entry[deparser_pkg::ENTRY_W-1-i*deparser_pkg::ACT_W -: deparser_pkg::ACT_W];

		container_extractor u_ext (
			.clk       (clk),
			.aresetn   (aresetn),
			.act_valid (act_valid),
			.act       (act),
			.phv       (phv_data),
			.field     (fields[i])
		);
	end

	depar_engine u_engine (
		.clk        (clk),
		.aresetn    (aresetn),
		.pkt_in     (pkt_in),
		.pkt_empty  (pkt_empty),
		.pkt_rd_en  (pkt_rd_en),
		.phv_data   (phv_data),
		.phv_empty  (phv_empty),
		.phv_rd_en  (phv_rd_en),
		.act_valid  (act_valid),
		.fields     (fields),
		.out_beat   (out_beat),
		.out_tvalid (out_tvalid),
		.out_tready (out_tready)
	);

endmodule

// File: dv/depar_checker.sv
module depar_checker (
	input  logic                            clk,
	input  logic                            aresetn,
	input  logic [deparser_pkg::DATA_W-1:0] ctrl_tdata,
	input  logic                            ctrl_tvalid,
	input  logic                            ctrl_tlast,
	input  deparser_pkg::axis_beat_t        pkt_beat,
	input  logic                            pkt_empty,
	input  logic                            pkt_rd_en,
	input  logic [deparser_pkg::PHV_W-1:0]  phv_data,
	input  logic                            phv_rd_en,
	input  deparser_pkg::axis_beat_t        out_beat,
	input  logic                            out_tvalid,
	input  logic                            out_tready,
	output int                              err_cnt,
	output int                              done_cnt
);

	deparser_pkg::axis_beat_t exp_q [$];
	int id_q [$];
	logic [deparser_pkg::ENTRY_W-1:0] tbl [deparser_pkg::TBL_DEPTH];
	int ctrl_beat;
	logic ctrl_hit;
	logic [3:0] ctrl_addr;
	logic in_pkt;
	int beat_no;
	int pkt_idx;
	logic [deparser_pkg::PHV_W-1:0] cur_phv;
	deparser_pkg::axis_beat_t first;
	int exp_id;
	int out_beats;
	logic pkt_bad;
	logic exp_phv_rd;

	task automatic check_val(input string name, input logic [255:0] e, input logic [255:0] a);
		if (e !== a) begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, e, a);
			err_cnt++;
			pkt_bad = 1'b1;
		end
	endtask

	// rewrites the first 64 bytes and queues the buffered beats
	task automatic push_rewritten(input deparser_pkg::axis_beat_t b0,
		input deparser_pkg::axis_beat_t b1, input logic two);
		logic [7:0] bytes [64];
		logic [deparser_pkg::ENTRY_W-1:0] ent;
		logic [15:0] act;
		logic [47:0] cont;
		int n;
		int o;
		int base;
		for (int i = 0; i < 32; i++) begin
			bytes[i] = b0.tdata[8*i +: 8];
			bytes[32 + i] = b1.tdata[8*i +: 8];
		end
		ent = tbl[cur_phv[deparser_pkg::PHV_VLAN_POS + 4 +: 4]];
		for (int a = 0; a < deparser_pkg::NUM_ACT; a++) begin
			act = ent[deparser_pkg::ENTRY_W - 1 - 16*a -: 16];
			// size in bytes is twice the type code
			n = 2 * int'(act[5:4]);
			o = int'(act[12:6]);
			case (act[5:4])
				2'b01: base = deparser_pkg::PHV_2B_POS;
				2'b10: base = deparser_pkg::PHV_4B_POS;
				default: base = deparser_pkg::PHV_6B_POS;
			endcase
			cont = cur_phv[base + 8*n*int'(act[3:1]) +: 48];
			if (act[0] && n > 0 && o + n <= 64) begin
				for (int k = 0; k < n; k++)
					bytes[o + k] = cont[8*(n-1-k) +: 8];
			end
		end
		for (int i = 0; i < 32; i++) begin
			b0.tdata[8*i +: 8] = bytes[i];
			b1.tdata[8*i +: 8] = bytes[32 + i];
		end
		b0.tuser = cur_phv[deparser_pkg::USER_W-1:0];
		exp_q.push_back(b0);
		id_q.push_back(pkt_idx);
		if (two) begin
			exp_q.push_back(b1);
			id_q.push_back(pkt_idx);
		end
	endtask

	task automatic take_pkt_beat();
		if (!in_pkt) begin
			in_pkt = 1'b1;
			beat_no = 0;
			pkt_idx++;
			cur_phv = phv_data;
			// a discarded phv leaves with the first packet beat
			exp_phv_rd = cur_phv[deparser_pkg::PHV_DISCARD_BIT];
		end
		if (!cur_phv[deparser_pkg::PHV_DISCARD_BIT]) begin
			if (beat_no == 0 && pkt_beat.tlast)
				push_rewritten(pkt_beat, '0, 1'b0);
			else if (beat_no == 0)
				first = pkt_beat;
			else if (beat_no == 1)
				push_rewritten(first, pkt_beat, 1'b1);
			else begin
				exp_q.push_back(pkt_beat);
				id_q.push_back(pkt_idx);
			end
		end else if (pkt_beat.tlast) begin
			$display("packet %0d: dropped", pkt_idx);
			done_cnt++;
		end
		beat_no++;
		if (pkt_beat.tlast)
			in_pkt = 1'b0;
	endtask

	task automatic check_out_beat();
		deparser_pkg::axis_beat_t e;
		if (exp_q.size() == 0) begin
			$display("unexpected output beat at %0t while no packet is pending", $time);
			err_cnt++;
		end else begin
			e = exp_q.pop_front();
			exp_id = id_q.pop_front();
			check_val("out_tdata", e.tdata, out_beat.tdata);
			check_val("out_tkeep", 256'(e.tkeep), 256'(out_beat.tkeep));
			check_val("out_tuser", 256'(e.tuser), 256'(out_beat.tuser));
			check_val("out_tlast", 256'(e.tlast), 256'(out_beat.tlast));
			// phv of a sent packet leaves with its first output beat
			if (out_beats == 0)
				exp_phv_rd = 1'b1;
			out_beats++;
			if (e.tlast) begin
				$display("packet %0d: %0d beats, %s", exp_id, out_beats,
					pkt_bad ? "mismatch" : "ok");
				done_cnt++;
				out_beats = 0;
				pkt_bad = 1'b0;
			end
		end
	endtask

	always @(posedge clk) begin
		if (!aresetn) begin
			ctrl_beat = 0;
			ctrl_hit = 1'b0;
			in_pkt = 1'b0;
			pkt_idx = 0;
			out_beats = 0;
			pkt_bad = 1'b0;
			exp_phv_rd = 1'b0;
			err_cnt = 0;
			done_cnt = 0;
		end else begin
			exp_phv_rd = 1'b0;
			if (ctrl_tvalid) begin
				if (ctrl_beat == 1) begin
					ctrl_hit = ctrl_tdata[deparser_pkg::CTRL_MOD_ID_POS +: 3]
						== deparser_pkg::DEPARSER_MOD_ID;
					ctrl_addr = ctrl_tdata[deparser_pkg::CTRL_ADDR_POS +: 4];
				end else if (ctrl_beat == 2 && ctrl_hit) begin
					// first 20 bytes of the beat with byte 0 on top
					for (int j = 0; j < 20; j++)
						tbl[ctrl_addr][8*j +: 8] = ctrl_tdata[8*(19-j) +: 8];
				end
				ctrl_beat = ctrl_tlast ? 0 : ctrl_beat + 1;
			end
			if (pkt_rd_en && !pkt_empty)
				take_pkt_beat();
			if (out_tvalid && out_tready)
				check_out_beat();
			check_val("phv_rd_en", 256'(exp_phv_rd), 256'(phv_rd_en));
		end
	end

endmodule

// File: dv/tb_deparser.sv
module tb_deparser;

	localparam logic [31:0] SEED = 32'hf19a;
	localparam int NUM_PKTS = 40;
	localparam int RESET_CYCLES = 16;
	localparam int SETTLE_CYCLES = 8;
	localparam int NUM_FOREIGN = 4;

	logic clk = 1'b0;
	logic aresetn;
	logic [deparser_pkg::DATA_W-1:0] ctrl_tdata;
	logic ctrl_tvalid;
	logic ctrl_tlast;
	deparser_pkg::axis_beat_t pkt_head;
	logic pkt_empty;
	logic pkt_rd_en;
	logic [deparser_pkg::PHV_W-1:0] phv_head;
	logic phv_empty;
	logic phv_rd_en;
	logic [deparser_pkg::DATA_W-1:0] out_tdata;
	logic [deparser_pkg::KEEP_W-1:0] out_tkeep;
	logic [deparser_pkg::USER_W-1:0] out_tuser;
	logic out_tlast;
	logic out_tvalid;
	logic out_tready;
	deparser_pkg::axis_beat_t out_b;

	logic [31:0] lfsr;
	deparser_pkg::axis_beat_t ctrl_q [$];
	deparser_pkg::axis_beat_t pkt_pend [$];
	deparser_pkg::axis_beat_t pkt_vis [$];
	logic [deparser_pkg::PHV_W-1:0] phv_pend [$];
	logic [deparser_pkg::PHV_W-1:0] phv_vis [$];
	int rst_cnt = 0;
	int settle = 0;
	int total_beats = 0;
	int limit = 0;
	int cycles = 0;
	int err_cnt;
	int done_cnt;

	assign out_b = {out_tdata, out_tkeep, out_tuser, out_tlast};

	// taps 32, 22, 2, 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic logic [deparser_pkg::PHV_W-1:0] rand_vec(input int n);
		logic [deparser_pkg::PHV_W-1:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v[i] = lfsr_bit();
		return v;
	endfunction

	task automatic add_ctrl(input logic [2:0] mod, input int addr, input int nbeats);
		logic [deparser_pkg::PHV_W-1:0] r;
		deparser_pkg::axis_beat_t b;
		for (int i = 0; i < nbeats; i++) begin
			r = rand_vec(deparser_pkg::DATA_W);
			b = '0;
			b.tdata = r[deparser_pkg::DATA_W-1:0];
			if (i == 1) begin
				b.tdata[deparser_pkg::CTRL_MOD_ID_POS +: 3] = mod;
				b.tdata[deparser_pkg::CTRL_ADDR_POS +: 4] = addr[3:0];
			end
			b.tlast = i == nbeats - 1;
			ctrl_q.push_back(b);
		end
	endtask

	task automatic add_packet();
		logic [deparser_pkg::PHV_W-1:0] r;
		deparser_pkg::axis_beat_t b;
		int len;
		int nbytes;
		r = rand_vec(deparser_pkg::PHV_W);
		// about one packet in eight is discarded
		r[deparser_pkg::PHV_DISCARD_BIT] = rand_bits(3) == 0;
		phv_pend.push_back(r);
		len = rand_bits(2) + 1;
		nbytes = rand_bits(5) + 1;
		for (int i = 0; i < len; i++) begin
			r = rand_vec(deparser_pkg::DATA_W + deparser_pkg::USER_W);
			b.tdata = r[deparser_pkg::DATA_W-1:0];
			b.tuser = r[deparser_pkg::DATA_W +: deparser_pkg::USER_W];
			b.tlast = i == len - 1;
			for (int k = 0; k < deparser_pkg::KEEP_W; k++)
				b.tkeep[k] = !b.tlast || k < nbytes;
			pkt_pend.push_back(b);
		end
		total_beats += len;
	endtask

	deparser_top UUT (
		.clk        (clk),
		.aresetn    (aresetn),
		.pkt_tdata  (pkt_head.tdata),
		.pkt_tkeep  (pkt_head.tkeep),
		.pkt_tuser  (pkt_head.tuser),
		.pkt_tlast  (pkt_head.tlast),
		.pkt_empty  (pkt_empty),
		.pkt_rd_en  (pkt_rd_en),
		.phv_data   (phv_head),
		.phv_empty  (phv_empty),
		.phv_rd_en  (phv_rd_en),
		.out_tdata  (out_tdata),
		.out_tkeep  (out_tkeep),
		.out_tuser  (out_tuser),
		.out_tlast  (out_tlast),
		.out_tvalid (out_tvalid),
		.out_tready (out_tready),
		.ctrl_tdata (ctrl_tdata),
		.ctrl_tvalid(ctrl_tvalid),
		.ctrl_tlast (ctrl_tlast)
	);

	depar_checker u_checker (
		.clk        (clk),
		.aresetn    (aresetn),
		.ctrl_tdata (ctrl_tdata),
		.ctrl_tvalid(ctrl_tvalid),
		.ctrl_tlast (ctrl_tlast),
		.pkt_beat   (pkt_head),
		.pkt_empty  (pkt_empty),
		.pkt_rd_en  (pkt_rd_en),
		.phv_data   (phv_head),
		.phv_rd_en  (phv_rd_en),
		.out_beat   (out_b),
		.out_tvalid (out_tvalid),
		.out_tready (out_tready),
		.err_cnt    (err_cnt),
		.done_cnt   (done_cnt)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	// inputs change on the falling edge only
	always @(negedge clk) begin
		if (rst_cnt < RESET_CYCLES) begin
			rst_cnt++;
			aresetn <= 1'b0;
		end else begin
			aresetn <= 1'b1;
			ctrl_tvalid <= 1'b0;
			if (ctrl_q.size() > 0) begin
				if (rand_bits(2) != 0) begin
					ctrl_tvalid <= 1'b1;
					ctrl_tdata <= ctrl_q[0].tdata;
					ctrl_tlast <= ctrl_q[0].tlast;
					ctrl_q.delete(0);
				end
			end else if (settle < SETTLE_CYCLES) begin
				settle++;
			end else begin
				// entries reach the show-ahead FIFOs at random times
				if (pkt_pend.size() > 0 && rand_bits(2) != 0)
					pkt_vis.push_back(pkt_pend.pop_front());
				if (phv_pend.size() > 0 && rand_bits(2) != 0)
					phv_vis.push_back(phv_pend.pop_front());
				out_tready <= rand_bits(2) != 0;
			end
		end
		pkt_empty <= pkt_vis.size() == 0;
		if (pkt_vis.size() > 0)
			pkt_head <= pkt_vis[0];
		phv_empty <= phv_vis.size() == 0;
		if (phv_vis.size() > 0)
			phv_head <= phv_vis[0];
	end

	always @(posedge clk) begin
		if (pkt_rd_en && pkt_vis.size() > 0)
			pkt_vis.delete(0);
		if (phv_rd_en && phv_vis.size() > 0)
			phv_vis.delete(0);
	end

	initial begin
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d of %0d packets finished", cycles, done_cnt,
			NUM_PKTS);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [2:0] mod;
		aresetn = 1'b0;
		ctrl_tdata = '0;
		ctrl_tvalid = 1'b0;
		ctrl_tlast = 1'b0;
		pkt_head = '0;
		pkt_empty = 1'b1;
		phv_head = '0;
		phv_empty = 1'b1;
		out_tready = 1'b0;
		lfsr = SEED;
		for (int a = 0; a < deparser_pkg::TBL_DEPTH; a++)
			add_ctrl(deparser_pkg::DEPARSER_MOD_ID, a, 3 + rand_bits(1));
		// these target loaded entries but carry another module id
		for (int a = 0; a < NUM_FOREIGN; a++) begin
			r = rand_bits(3);
			mod = r[2:0];
			if (mod == deparser_pkg::DEPARSER_MOD_ID)
				mod = 3'b001;
			add_ctrl(mod, a, 3);
		end
		total_beats = ctrl_q.size();
		for (int p = 0; p < NUM_PKTS; p++)
			add_packet();
		limit = 20 * total_beats + 200;
		wait (done_cnt == NUM_PKTS);
		repeat (10) @(posedge clk);
		$display("%0d packets finished, %0d errors", done_cnt, err_cnt);
		if (err_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: list.f
hdl/deparser_pkg.sv
hdl/depar_ctrl_loader.sv
hdl/depar_action_table.sv
hdl/container_extractor.sv
hdl/depar_engine.sv
hdl/deparser_top.sv
dv/depar_checker.sv
dv/tb_deparser.sv
